// File: logic/conv_pkg.sv
//----------------------------------------
// Grid constants, the input beat union
// and the control word of the MAC pipe
//----------------------------------------
package conv_pkg;

  //----------------------------------------
  // Grid and field sizes
  //----------------------------------------
  localparam int ROWS      = 4;   // Pixels per beat
  localparam int COLS      = 2;   // Weights per beat
  localparam int W_IN      = 8;   // Signed operands
  localparam int LEN_W     = 8;
  localparam int SHIFT_W   = 5;
  localparam int PAYLOAD_W = (ROWS + COLS) * W_IN;

  // Data view of a beat
  typedef struct packed {
    logic [ROWS-1:0][W_IN-1:0] pixels;
    logic [COLS-1:0][W_IN-1:0] weights;
  } data_word_t;

  // Config view of a beat
  typedef struct packed {
    logic [LEN_W-1:0]                   sum_len;    // Kernel length, 1 to 255
    logic [SHIFT_W-1:0]                 out_shift;
    logic [PAYLOAD_W-LEN_W-SHIFT_W-1:0] reserved;
  } cfg_word_t;

  // Same 48 bits, decoded by is_cfg
  typedef union packed {
    data_word_t data;
    cfg_word_t  cfg;
  } beat_payload_u;

  typedef struct packed {
    logic          is_cfg;
    beat_payload_u payload;
  } in_beat_t;

  //----------------------------------------
  // Control that follows each data beat
  //----------------------------------------
  typedef struct packed {
    logic               valid;
    logic               first;   // Clears the accumulators
    logic               last;    // Sum complete after this beat
    logic [SHIFT_W-1:0] out_shift;
  } sum_ctrl_t;

endpackage

// File: logic/beat_decoder.sv
//----------------------------------------
// Beat decoder with input register,
// config holding, data beat counting and
// the operand and control registers
//----------------------------------------
`timescale 1ns/1ns

module beat_decoder (
  input  logic                                          clk,
  input  logic                                          i_rst,
  input  logic                                          i_en,
  input  logic                                          i_valid,
  input  conv_pkg::in_beat_t                            i_beat,
  output conv_pkg::sum_ctrl_t                           o_ctrl,
  output logic [conv_pkg::ROWS-1:0][conv_pkg::W_IN-1:0] o_pixels,
  output logic [conv_pkg::COLS-1:0][conv_pkg::W_IN-1:0] o_weights
);

  localparam logic [conv_pkg::LEN_W-1:0] LEN_DEFAULT = 1;

  logic                         beat_valid;
  conv_pkg::in_beat_t           beat_q;
  logic                         is_cfg;
  logic                         is_data;
  logic [conv_pkg::LEN_W-1:0]   sum_len;
  logic [conv_pkg::SHIFT_W-1:0] out_shift;
  logic [conv_pkg::LEN_W-1:0]   count;
  logic                         count_last;

  //----------------------------------------
  // Input register
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (i_rst) begin
      beat_valid <= 1'b0;
    end else if (i_en) begin
      beat_valid <= i_valid;   // Already gated with the handshake
    end
  end

  always_ff @(posedge clk) begin
    if (i_en && i_valid) begin
      beat_q <= i_beat;
    end
  end

  assign is_cfg     = beat_valid && beat_q.is_cfg;
  assign is_data    = beat_valid && !beat_q.is_cfg;
  assign count_last = (count == sum_len - 1'b1);

  //----------------------------------------
  // Config and beat counter
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (i_rst) begin
      sum_len   <= LEN_DEFAULT;
      out_shift <= '0;
      count     <= '0;
    end else if (i_en) begin
      if (is_cfg) begin
        sum_len   <= beat_q.payload.cfg.sum_len;
        out_shift <= beat_q.payload.cfg.out_shift;
        count     <= '0;   // Partial sum is dropped
      end else if (is_data) begin
        count <= count_last ? '0 : count + 1'b1;
      end
    end
  end

  // Control toward the MAC grid
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_ctrl <= '0;
    end else if (i_en) begin
      o_ctrl.valid     <= is_data;
      o_ctrl.first     <= (count == '0);
      o_ctrl.last      <= count_last;
      o_ctrl.out_shift <= out_shift;
    end
  end

  // Operands, data view of the payload
  always_ff @(posedge clk) begin
    if (i_en && is_data) begin
      o_pixels  <= beat_q.payload.data.pixels;
      o_weights <= beat_q.payload.data.weights;
    end
  end

endmodule

// File: logic/mac_element.sv
//----------------------------------------
// One grid element, registered signed
// multiply and an accumulator that loads
// on the first beat of a sum
//----------------------------------------
`timescale 1ns/1ns

module mac_element #(
  parameter int ACC_W = 24
) (
  input  logic                      clk,
  input  logic                      i_rst,
  input  logic                      i_en,
  input  logic [conv_pkg::W_IN-1:0] i_pixel,
  input  logic [conv_pkg::W_IN-1:0] i_weight,
  input  logic                      i_mul_valid,
  input  logic                      i_first,
  output logic signed [ACC_W-1:0]   o_acc
);

  localparam int PROD_W = 2 * conv_pkg::W_IN;

  logic signed [PROD_W-1:0] product;
  logic signed [ACC_W-1:0]  product_ext;
  logic signed [ACC_W-1:0]  acc_base;

  //----------------------------------------
  // Multiplier stage
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (i_en) begin
      product <= $signed(i_pixel) * $signed(i_weight);
    end
  end

  assign product_ext = ACC_W'(product);       // Sign extended
  assign acc_base    = i_first ? '0 : o_acc;  // Bypass old sum on first beat

  //----------------------------------------
  // Accumulator stage
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_acc <= '0;
    end else if (i_en && i_mul_valid) begin
      o_acc <= acc_base + product_ext;
    end
  end

endmodule

// File: logic/result_stage.sv
//----------------------------------------
// Output stage that shifts the finished
// grid and holds it in a two-entry skid
// buffer toward the result stream
//----------------------------------------
`timescale 1ns/1ns

module result_stage #(
  parameter int ACC_W = 24
) (
  input  logic                                                 clk,
  input  logic                                                 i_rst,
  input  logic                                                 i_capture,
  input  logic [conv_pkg::SHIFT_W-1:0]                         i_shift,
  input  logic [conv_pkg::COLS-1:0][conv_pkg::ROWS-1:0][ACC_W-1:0] i_grid,
  input  logic                                                 i_ready,
  output logic                                                 o_full,
  output logic                                                 o_valid,
  output logic [conv_pkg::COLS-1:0][conv_pkg::ROWS-1:0][ACC_W-1:0] o_data
);

  typedef logic [conv_pkg::COLS-1:0][conv_pkg::ROWS-1:0][ACC_W-1:0] grid_t;

  logic                         capture_q;
  logic [conv_pkg::SHIFT_W-1:0] shift_q;
  logic                         push;
  logic                         pop;
  logic                         skid_valid;
  grid_t                        shifted;
  grid_t                        skid_data;

  assign o_full = skid_valid;               // Both entries taken
  assign push   = capture_q && !skid_valid;
  assign pop    = o_valid && i_ready;

  //----------------------------------------
  // Capture request
  //----------------------------------------
  // Control arrives with the products, so it is held one cycle
  // until the accumulators carry the final sums
  always_ff @(posedge clk) begin
    if (i_rst) begin
      capture_q <= 1'b0;
    end else if (!skid_valid) begin
      capture_q <= i_capture;
    end
  end

  always_ff @(posedge clk) begin
    if (!skid_valid) begin
      shift_q <= i_shift;
    end
  end

  // Arithmetic shift of every sum
  always_comb begin
    for (int c = 0; c < conv_pkg::COLS; c++) begin
      for (int r = 0; r < conv_pkg::ROWS; r++) begin
        shifted[c][r] = ACC_W'($signed(i_grid[c][r]) >>> shift_q);
      end
    end
  end

  //----------------------------------------
  // Skid buffer
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (push && o_valid && !pop) begin
        skid_valid <= 1'b1;   // Output stalled, park in overflow
      end else if (pop) begin
        skid_valid <= 1'b0;
      end

      if (push) begin
        o_valid <= 1'b1;
      end else if (pop && !skid_valid) begin
        o_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push && (!o_valid || pop)) begin
      o_data <= shifted;
    end else if (pop && skid_valid) begin
      o_data <= skid_data;
    end
  end

  always_ff @(posedge clk) begin
    if (push && o_valid && !pop) begin
      skid_data <= shifted;
    end
  end

endmodule

// File: logic/conv_engine.sv
//----------------------------------------
// Convolution engine top with decoder,
// MAC grid, result stage and the global
// pipeline enable
//----------------------------------------
`timescale 1ns/1ns

module conv_engine #(
  parameter int ACC_W = 24
) (
  input  logic                                                 clk,
  input  logic                                                 i_rst,

  // Input stream
  input  logic                                                 i_valid,
  input  conv_pkg::in_beat_t                                   i_beat,
  output logic                                                 o_ready,

  // Result stream
  input  logic                                                 i_ready,
  output logic                                                 o_valid,
  output logic [conv_pkg::COLS-1:0][conv_pkg::ROWS-1:0][ACC_W-1:0] o_data
);

  logic                                                 en;
  logic                                                 full;
  logic                                                 in_take;
  conv_pkg::sum_ctrl_t                                  dec_ctrl;
  conv_pkg::sum_ctrl_t                                  ctrl_s2;
  logic [conv_pkg::ROWS-1:0][conv_pkg::W_IN-1:0]        pixels;
  logic [conv_pkg::COLS-1:0][conv_pkg::W_IN-1:0]        weights;
  logic [conv_pkg::COLS-1:0][conv_pkg::ROWS-1:0][ACC_W-1:0] acc_grid;

  assign en      = !full;          // Whole pipe stalls on a full skid buffer
  assign o_ready = en;
  assign in_take = i_valid && en;

  beat_decoder DECODER (
    .clk       (clk     ),
    .i_rst     (i_rst   ),
    .i_en      (en      ),
    .i_valid   (in_take ),
    .i_beat    (i_beat  ),
    .o_ctrl    (dec_ctrl),
    .o_pixels  (pixels  ),
    .o_weights (weights )
  );

  //----------------------------------------
  // Stage-2 control, next to the products
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (i_rst) begin
      ctrl_s2 <= '0;
    end else if (en) begin
      ctrl_s2 <= dec_ctrl;
    end
  end

  // Column c takes weight c, row r takes pixel r
  for (genvar c = 0; c < conv_pkg::COLS; c++) begin : COL
    for (genvar r = 0; r < conv_pkg::ROWS; r++) begin : ROW
      mac_element #(
        .ACC_W (ACC_W)
      ) MAC (
        .clk         (clk           ),
        .i_rst       (i_rst         ),
        .i_en        (en            ),
        .i_pixel     (pixels[r]     ),
        .i_weight    (weights[c]    ),
        .i_mul_valid (ctrl_s2.valid ),
        .i_first     (ctrl_s2.first ),
        .o_acc       (acc_grid[c][r])
      );
    end
  end

  result_stage #(
    .ACC_W (ACC_W)
  ) RESULT (
    .clk       (clk                          ),
    .i_rst     (i_rst                        ),
    .i_capture (ctrl_s2.valid && ctrl_s2.last),
    .i_shift   (ctrl_s2.out_shift            ),
    .i_grid    (acc_grid                     ),
    .i_ready   (i_ready                      ),
    .o_full    (full                         ),
    .o_valid   (o_valid                      ),
    .o_data    (o_data                       )
  );

endmodule

// File: sim/conv_model.svh
//----------------------------------------
// Reference model state and tasks, and
// the Galois LFSR for random stimulus
//----------------------------------------
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

localparam int M_ACC_W = 24;
typedef logic [conv_pkg::COLS-1:0][conv_pkg::ROWS-1:0][M_ACC_W-1:0] grid_t;

logic [31:0] lfsr_state = 32'd89036;
int          m_sum_len  = 1;
int          m_shift    = 0;
int          m_count    = 0;
int          m_errors   = 0;
int          m_checked  = 0;
longint      m_sum [conv_pkg::COLS][conv_pkg::ROWS];
grid_t       exp_q [$];

// One bit per LFSR step
function automatic logic [31:0] lfsr_take(input int unsigned n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
    v = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

task automatic model_config(input int sum_len, input int shift);
  m_sum_len = sum_len;
  m_shift   = shift;
  m_count   = 0;   // Partial sum dropped
endtask

task automatic model_data(input conv_pkg::data_word_t d);
  grid_t g;
  longint p;
  for (int c = 0; c < conv_pkg::COLS; c++) begin
    for (int r = 0; r < conv_pkg::ROWS; r++) begin
      p = longint'($signed(d.pixels[r])) * longint'($signed(d.weights[c]));
      m_sum[c][r] = (m_count == 0) ? p : m_sum[c][r] + p;
      g[c][r] = M_ACC_W'(m_sum[c][r] >>> m_shift);
    end
  end
  m_count++;
  if (m_count == m_sum_len) begin
    exp_q.push_back(g);
    m_count = 0;
  end
endtask

task automatic model_check(input grid_t act, input string test);
  grid_t e;
  if (exp_q.size() == 0) begin
    $display("ERROR %s unexpected result %h", test, act);
    m_errors++;
    return;
  end
  e = exp_q.pop_front();
  m_checked++;
  for (int c = 0; c < conv_pkg::COLS; c++) begin
    for (int r = 0; r < conv_pkg::ROWS; r++) begin
      if (e[c][r] !== act[c][r]) begin
        $display("ERROR %s [%0d][%0d] expected %0d actual %0d", test, c, r,
                 $signed(e[c][r]), $signed(act[c][r]));
        m_errors++;
      end
    end
  end
endtask

`endif

// File: sim/tb_conv_engine.sv
//----------------------------------------
// Testbench for the convolution engine
// Random beats, model queue, watchdog
//----------------------------------------
`timescale 1ns/1ns

module tb_conv_engine;

  `include "conv_model.svh"

  localparam int ACC_W = 24;

  logic               clk;
  logic               i_rst;
  logic               i_valid;
  conv_pkg::in_beat_t i_beat;
  logic               o_ready;
  logic               i_ready;
  logic               o_valid;
  grid_t              o_data;

  int    cycle;
  int    beats_total = 0;
  int    seq_errors  = 0;
  int    valid_mode  = 1;   // 0 always high, 1 random
  int    ready_mode  = 0;   // 0 high, 1 random, 2 long runs, 3 low
  int    last_hs_cycle;
  int    out_cycles [$];
  string test_name   = "reset_state";

  conv_engine #(
    .ACC_W (ACC_W)
  ) UUT (
    .clk     (clk    ),
    .i_rst   (i_rst  ),
    .i_valid (i_valid),
    .i_beat  (i_beat ),
    .o_ready (o_ready),
    .i_ready (i_ready),
    .o_valid (o_valid),
    .o_data  (o_data )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //----------------------------------------
  // Stimulus helpers
  //----------------------------------------
  function automatic logic [conv_pkg::W_IN-1:0] random_byte();
    return (lfsr_take(3) == 0) ? 8'h80 : 8'(lfsr_take(8));   // Often -128
  endfunction

  function automatic conv_pkg::data_word_t random_operands();
    conv_pkg::data_word_t d;
    for (int r = 0; r < conv_pkg::ROWS; r++) begin
      d.pixels[r] = random_byte();
    end
    for (int c = 0; c < conv_pkg::COLS; c++) begin
      d.weights[c] = random_byte();
    end
    return d;
  endfunction

  // Holds the beat until it is taken, then updates the model
  task automatic send_beat(input conv_pkg::in_beat_t b);
    logic done;
    done = 1'b0;
    beats_total++;
    i_beat  <= b;
    i_valid <= (valid_mode == 0) || (lfsr_take(2) != 0);
    while (!done) begin
      @(posedge clk);
      if (i_valid && o_ready) begin
        done = 1'b1;
      end else begin
        i_valid <= (valid_mode == 0) || (lfsr_take(2) != 0);
      end
    end
    last_hs_cycle = cycle;
    if (b.is_cfg) begin
      model_config(int'(b.payload.cfg.sum_len), int'(b.payload.cfg.out_shift));
    end else begin
      model_data(b.payload.data);
    end
  endtask

  task automatic send_config(input int len, input int shift);
    conv_pkg::in_beat_t b;
    b = '0;
    b.is_cfg                = 1'b1;
    b.payload.cfg.sum_len   = 8'(len);
    b.payload.cfg.out_shift = 5'(shift);
    send_beat(b);
  endtask

  task automatic send_sum(input int n);
    conv_pkg::in_beat_t b;
    for (int i = 0; i < n; i++) begin
      b = '0;
      b.payload.data = random_operands();
      send_beat(b);
    end
  endtask

  task automatic drain_results();
    i_valid <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
  endtask

  task automatic apply_reset();
    i_rst   <= 1'b1;
    i_valid <= 1'b0;
    repeat (5) @(posedge clk);
    i_rst <= 1'b0;
    model_config(1, 0);   // Defaults after reset
    exp_q.delete();       // Pending results are lost
  endtask

  task automatic check_reset_state();
    @(posedge clk);
    if (o_valid !== 1'b0) begin
      $display("ERROR %s o_valid expected 0 actual %b", test_name, o_valid);
      seq_errors++;
    end
    if (o_ready !== 1'b1) begin
      $display("ERROR %s o_ready expected 1 actual %b", test_name, o_ready);
      seq_errors++;
    end
  endtask

  //----------------------------------------
  // Output side
  //----------------------------------------
  initial begin
    int run_left;
    run_left = 0;
    i_ready <= 1'b1;
    forever begin
      @(posedge clk);
      if (ready_mode == 0) begin
        i_ready <= 1'b1;
      end else if (ready_mode == 3) begin
        i_ready <= 1'b0;
      end else if (ready_mode == 1) begin
        i_ready <= (lfsr_take(1) != 0);
      end else if (run_left == 0) begin
        i_ready  <= (lfsr_take(1) != 0);
        run_left = int'(lfsr_take(4)) + 1;   // Runs of 1 to 16 cycles
      end else begin
        run_left--;
      end
    end
  end

  initial begin
    logic  stalled;
    grid_t held;
    stalled = 1'b0;
    cycle <= 0;
    forever begin
      @(posedge clk);
      cycle <= cycle + 1;
      if (i_rst) begin
        stalled = 1'b0;
      end else begin
        if (stalled && !o_valid) begin
          $display("o_valid dropped in %s while the output was stalled", test_name);
          m_errors++;
        end else if (stalled && o_data !== held) begin
          $display("ERROR %s stalled data expected %h actual %h", test_name, held, o_data);
          m_errors++;
        end
        if (o_valid && i_ready) begin
          model_check(o_data, test_name);
          out_cycles.push_back(cycle);
        end
        stalled = o_valid && !i_ready;
        held    = o_data;
      end
    end
  end

  // Four cycles per beat sent, plus slack
  initial begin
    int wd_cycles;
    wd_cycles = 0;
    while (wd_cycles < (beats_total + 50) * 4) begin
      @(posedge clk);
      wd_cycles++;
    end
    $display("Timeout after %0d cycles with %0d beats sent", wd_cycles, beats_total);
    $display("Checked %0d results, %0d model errors, %0d other errors",
             m_checked, m_errors, seq_errors);
    $display("*** TEST FAILED ***");
    $finish;
  end

  //----------------------------------------
  // Test sequence
  //----------------------------------------
  initial begin
    int len;
    int first_hs;
    int base;
    i_beat <= '0;
    apply_reset();
    check_reset_state();
    send_sum(1);
    drain_results();

    test_name = "single_beat";
    send_config(1, 0);
    send_sum(40);
    drain_results();

    test_name = "long_sums";
    send_config(255, 3);   // Largest magnitude
    send_sum(255);
    for (int s = 0; s < 6; s++) begin
      len = int'(lfsr_take(8));
      if (len == 0) begin
        len = 255;
      end
      send_config(len, int'(lfsr_take(5)));
      send_sum(len);
    end
    drain_results();

    test_name = "reconfig";
    send_config(5, 2);
    send_sum(10);
    send_sum(2);           // Partial sum, dropped by the config below
    send_config(3, 7);
    send_sum(9);
    send_config(1, 1);
    send_sum(4);
    drain_results();

    test_name  = "backpressure";
    ready_mode = 1;
    send_config(1, 0);
    send_sum(60);
    ready_mode = 2;
    send_config(2, 1);
    send_sum(120);
    drain_results();
    ready_mode = 0;

    test_name  = "throughput";
    valid_mode = 0;
    send_config(1, 0);
    base = out_cycles.size();
    send_sum(1);
    first_hs = last_hs_cycle;
    send_sum(19);
    drain_results();
    if (out_cycles.size() != base + 20) begin
      $display("Throughput test saw %0d results instead of 20", out_cycles.size() - base);
      seq_errors++;
    end else begin
      // o_valid is seen one edge after the edge that sets it
      if (out_cycles[base] - first_hs - 1 != 4) begin
        $display("ERROR %s latency expected 4 actual %0d", test_name,
                 out_cycles[base] - first_hs - 1);
        seq_errors++;
      end
      if (out_cycles[base + 19] - out_cycles[base] != 19) begin
        $display("ERROR %s cycles for 20 results expected 19 actual %0d", test_name,
                 out_cycles[base + 19] - out_cycles[base]);
        seq_errors++;
      end
    end

    test_name  = "reset_defaults";
    valid_mode = 1;
    ready_mode = 3;        // Keep a result waiting at the output
    send_config(7, 4);
    send_sum(10);          // One sum and three beats of the next
    i_valid <= 1'b0;
    while (!o_valid) @(posedge clk);
    apply_reset();
    ready_mode = 0;
    check_reset_state();
    send_sum(3);
    drain_results();

    if (exp_q.size() != 0) begin
      $display("%0d expected results never came out", exp_q.size());
      seq_errors++;
    end
    $display("Checked %0d results, %0d model errors, %0d other errors",
             m_checked, m_errors, seq_errors);
    if (m_errors + seq_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: conv_engine.f
+incdir+sim
logic/conv_pkg.sv
logic/beat_decoder.sv
logic/mac_element.sv
logic/result_stage.sv
logic/conv_engine.sv
sim/tb_conv_engine.sv

// File: build.sh
#!/bin/sh
# Compile and run the convolution engine testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
  --top-module tb_conv_engine \
  -f conv_engine.f \
  -o tb_conv_engine

./obj_dir/tb_conv_engine > sim.log 2>&1
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
